/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_rv_core
FILE_LIST = sources.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* source/alu.sv */
`timescale 1ns/100ps

module alu import rv_core_pkg::*; (
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] result,
    output logic            branch_taken
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] raw;

    always_comb begin
        // lui reaches here with rs1 forced to x0
        if (ctrl.alu_src == src_four_pc || ctrl.alu_src == src_imm_pc) begin
            op_a = pc;
        end else begin
            op_a = rs1_data;
        end

        case (ctrl.alu_src)
            src_reg:     op_b = rs2_data;
            src_four_pc: op_b = xlen'(4);
            default:     op_b = imm;
        endcase

        case (ctrl.alu_op)
            alu_sub:  raw = op_a - op_b;
            alu_sltu: raw = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_sra:  raw = $signed(op_a) >>> op_b[5:0];
            default:  raw = op_a + op_b;
        endcase

        result = ctrl.word_op ? {{(xlen-32){raw[31]}}, raw[31:0]} : raw;
    end

    assign branch_taken = ctrl.branch & ((rs1_data == rs2_data) == ctrl.branch_on_equal);

endmodule

/* source/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen import rv_core_pkg::*; (
    input  rv_inst_u        inst,
    input  imm_fmt_e        imm_fmt,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (imm_fmt)
            imm_s: begin
                imm = {{(xlen-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi,
                       inst.s_fmt.imm_lo};
            end
            imm_b: begin
                imm = {{(xlen-13){inst.b_fmt.imm_12}}, inst.b_fmt.imm_12,
                       inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                       inst.b_fmt.imm_4_1, 1'b0};
            end
            imm_u: begin
                imm = {{(xlen-32){inst.u_fmt.imm_31_12[19]}}, inst.u_fmt.imm_31_12,
                       12'h000};
            end
            imm_j: begin
                imm = {{(xlen-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20,
                       inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                       inst.j_fmt.imm_10_1, 1'b0};
            end
            default: begin
                imm = {{(xlen-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm}; // i format
            end
        endcase
    end

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder import rv_core_pkg::*; (
    input  rv_inst_u inst,
    output ctrl_t    ctrl,
    output logic     is_ebreak,
    output logic     illegal
);

    assign is_ebreak = (inst == inst_ebreak);

    always_comb begin
        ctrl.rs1             = inst.r_fmt.rs1;
        ctrl.rs2             = inst.r_fmt.rs2;
        ctrl.rd              = inst.r_fmt.rd;
        ctrl.reg_wen         = 1'b0;
        ctrl.imm_fmt         = imm_i;
        ctrl.alu_op          = alu_add;
        ctrl.alu_src         = src_reg;
        ctrl.branch          = 1'b0;
        ctrl.branch_on_equal = 1'b0;
        ctrl.jump            = 1'b0;
        ctrl.jalr            = 1'b0;
        ctrl.load_kind       = load_none;
        ctrl.store_wmask     = 8'h00;
        ctrl.word_op         = 1'b0;
        illegal              = 1'b0;

        case (inst.r_fmt.opcode)
            opc_op: begin
                ctrl.reg_wen = 1'b1;
                case ({inst.r_fmt.funct7, inst.r_fmt.funct3})
                    10'b0000000_000: ctrl.alu_op = alu_add;
                    10'b0100000_000: ctrl.alu_op = alu_sub;
                    default:         illegal = 1'b1;
                endcase
            end
            opc_op_imm: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_imm;
                case (inst.i_fmt.funct3)
                    3'b000: ctrl.alu_op = alu_add;  // addi
                    3'b011: ctrl.alu_op = alu_sltu; // sltiu
                    3'b101: begin
                        if (inst.i_fmt.imm[11:6] == 6'b010000) begin
                            ctrl.alu_op = alu_sra;  // srai, shamt in imm[5:0]
                        end else begin
                            illegal = 1'b1;         // srli not supported
                        end
                    end
                    default: illegal = 1'b1;
                endcase
            end
            opc_op_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.word_op = 1'b1;
                if ({inst.r_fmt.funct7, inst.r_fmt.funct3} != 10'b0000000_000) begin
                    illegal = 1'b1;                 // only addw
                end
            end
            opc_op_imm_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_imm;
                ctrl.word_op = 1'b1;
                if (inst.i_fmt.funct3 != 3'b000) begin
                    illegal = 1'b1;                 // only addiw
                end
            end
            opc_load: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_imm;
                case (inst.i_fmt.funct3)
                    3'b010:  ctrl.load_kind = load_word_signed;
                    3'b011:  ctrl.load_kind = load_double;
                    3'b100:  ctrl.load_kind = load_byte_unsigned;
                    default: illegal = 1'b1;
                endcase
            end
            opc_store: begin
                ctrl.imm_fmt = imm_s;
                ctrl.alu_src = src_imm;
                case (inst.s_fmt.funct3)
                    3'b011:  ctrl.store_wmask = 8'hff; // sd
                    3'b001:  ctrl.store_wmask = 8'h03; // sh
                    default: illegal = 1'b1;
                endcase
            end
            opc_jal: begin
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.imm_fmt = imm_j;
                ctrl.alu_src = src_four_pc;         // link pc + 4
            end
            opc_jalr: begin
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.alu_src = src_four_pc;
                if (inst.i_fmt.funct3 != 3'b000) begin
                    illegal = 1'b1;
                end
            end
            opc_lui: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rs1     = '0;                  // x0 + imm
                ctrl.imm_fmt = imm_u;
                ctrl.alu_src = src_imm;
            end
            opc_auipc: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_fmt = imm_u;
                ctrl.alu_src = src_imm_pc;
            end
            opc_branch: begin
                ctrl.imm_fmt = imm_b;
                case (inst.b_fmt.funct3)
                    3'b000: begin
                        ctrl.branch          = 1'b1;
                        ctrl.branch_on_equal = 1'b1;
                    end
                    3'b001:  ctrl.branch = 1'b1;
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = ~is_ebreak;
        endcase

        // unknown encodings retire as a no-op
        if (illegal) begin
            ctrl.reg_wen     = 1'b0;
            ctrl.branch      = 1'b0;
            ctrl.jump        = 1'b0;
            ctrl.jalr        = 1'b0;
            ctrl.load_kind   = load_none;
            ctrl.store_wmask = 8'h00;
        end
    end

endmodule

/* source/lsu.sv */
`timescale 1ns/100ps

module lsu import rv_core_pkg::*; (
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] alu_result,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] dmem_rdata,
    input  logic            run,
    output dmem_req_t       dmem_req,
    output logic [xlen-1:0] wb_data
);

    logic [2:0]      lane;
    logic [xlen-1:0] lane_data;
    logic [xlen-1:0] load_data;

    assign lane = alu_result[2:0]; // byte offset in the doubleword

    always_comb begin
        dmem_req.addr  = alu_result;
        dmem_req.wdata = rs2_data << {lane, 3'b000};
        dmem_req.wmask = ctrl.store_wmask << lane;
        dmem_req.wen   = run & (|ctrl.store_wmask);
        dmem_req.ren   = run & (ctrl.load_kind != load_none);
    end

    assign lane_data = dmem_rdata >> {lane, 3'b000};

    always_comb begin
        case (ctrl.load_kind)
            load_word_signed: begin
                load_data = {{(xlen-32){lane_data[31]}}, lane_data[31:0]};
            end
            load_byte_unsigned: begin
                load_data = {{(xlen-8){1'b0}}, lane_data[7:0]};
            end
            default: begin
                load_data = lane_data; // ld, lane is zero when aligned
            end
        endcase
    end

    assign wb_data = (ctrl.load_kind != load_none) ? load_data : alu_result;

endmodule

/* source/pc_unit.sv */
`timescale 1ns/100ps

module pc_unit import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] rs1_data,
    input  logic            branch_taken,
    input  logic            is_ebreak,
    output logic [xlen-1:0] pc,
    output logic            run,
    output logic            halt,
    output imem_req_t       imem_req
);

    logic            started; // first edge out of reset seen
    logic [xlen-1:0] jalr_target;
    logic [xlen-1:0] next_pc;

    assign jalr_target = rs1_data + imm;

    always_comb begin
        if (ctrl.jalr) begin
            next_pc = {jalr_target[xlen-1:1], 1'b0};
        end else if (ctrl.jump || branch_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + xlen'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= reset_pc;
            halt    <= 1'b0;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (run && is_ebreak) begin
                halt <= 1'b1; // pc parks on the ebreak
            end else if (run) begin
                pc <= next_pc;
            end
        end
    end

    assign run           = started & ~halt;
    assign imem_req.addr = pc;

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file import rv_core_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [reg_addr_width-1:0] rs1,
    input  logic [reg_addr_width-1:0] rs2,
    input  logic [reg_addr_width-1:0] rd,
    input  logic                      wen,
    input  logic [xlen-1:0]           wdata,
    output logic [xlen-1:0]           rs1_data,
    output logic [xlen-1:0]           rs2_data
);

    logic [xlen-1:0] regs [2**reg_addr_width];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* source/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int xlen           = 64;
    localparam int inst_width     = 32;
    localparam int reg_addr_width = 5;
    localparam logic [xlen-1:0] reset_pc = 64'h0;

    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_branch    = 7'b1100011;

    localparam logic [inst_width-1:0] inst_ebreak = 32'h0010_0073;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_sltu, alu_sra} alu_op_e;
    typedef enum logic [2:0] {src_reg, src_imm, src_four_pc, src_imm_pc} alu_src_e;
    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_fmt_e;
    typedef enum logic [1:0] {
        load_none, load_word_signed, load_double, load_byte_unsigned
    } load_kind_e;

    typedef struct packed {
        logic [6:0]                funct7;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]               imm;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]                imm_hi;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [4:0]                imm_lo;
        logic [6:0]                opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                      imm_12;
        logic [5:0]                imm_10_5;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [3:0]                imm_4_1;
        logic                      imm_11;
        logic [6:0]                opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]               imm_31_12;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                      imm_20;
        logic [9:0]                imm_10_1;
        logic                      imm_11;
        logic [7:0]                imm_19_12;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_inst_u;

    typedef struct packed {
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rd;
        logic                      reg_wen;
        imm_fmt_e                  imm_fmt;
        alu_op_e                   alu_op;
        alu_src_e                  alu_src;
        logic                      branch;
        logic                      branch_on_equal; // beq when set, bne otherwise
        logic                      jump;
        logic                      jalr;
        load_kind_e                load_kind;
        logic [7:0]                store_wmask;
        logic                      word_op;         // sign-extend low word of result
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic [7:0]      wmask;
        logic            wen;
        logic            ren;
    } dmem_req_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
    } imem_req_t;

endpackage

/* source/rv_core_top.sv */
`timescale 1ns/100ps

module rv_core_top import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [inst_width-1:0] imem_rdata,
    output imem_req_t             imem_req,
    output dmem_req_t             dmem_req,
    input  logic [xlen-1:0]       dmem_rdata,
    output logic                  halt,
    output logic                  illegal
);

    ctrl_t           ctrl;
    logic            is_ebreak;
    logic            run;
    logic            branch_taken;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;

    inst_decoder u_inst_decoder (
        .inst      (imem_rdata),
        .ctrl      (ctrl),
        .is_ebreak (is_ebreak),
        .illegal   (illegal)
    );

    imm_gen u_imm_gen (
        .inst    (imem_rdata),
        .imm_fmt (ctrl.imm_fmt),
        .imm     (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rd       (ctrl.rd),
        .wen      (ctrl.reg_wen & run), // no writes in reset or halt
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu u_alu (
        .ctrl         (ctrl),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    lsu u_lsu (
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .dmem_rdata (dmem_rdata),
        .run        (run),
        .dmem_req   (dmem_req),
        .wb_data    (wb_data)
    );

    pc_unit u_pc_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .imm          (imm),
        .rs1_data     (rs1_data),
        .branch_taken (branch_taken),
        .is_ebreak    (is_ebreak),
        .pc           (pc),
        .run          (run),
        .halt         (halt),
        .imem_req     (imem_req)
    );

endmodule

/* sources.f */
source/rv_core_pkg.sv
source/inst_decoder.sv
source/imm_gen.sv
source/reg_file.sv
source/alu.sv
source/lsu.sv
source/pc_unit.sv
source/rv_core_top.sv
+incdir+tests
tests/tb_rv_core.sv

/* tests/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int prog_len   = 48;
localparam int illegal_pc = 46 * 4;
localparam int n_stores   = 17;
localparam int n_loads    = 3;
localparam logic [63:0] poison_addr = 64'h158;

localparam logic [63:0] exp_addr [n_stores] = '{
    64'h1f8, 64'h100, 64'h108, 64'h110, 64'h118, 64'h120, 64'h128, 64'h130,
    64'h138, 64'h140, 64'h148, 64'h150, 64'h192, 64'h160, 64'h168, 64'h170,
    64'h178
};
localparam logic [63:0] exp_data [n_stores] = '{
    64'h0, 64'd93, 64'd107, 64'd1,
    64'hffff_ffff_ffff_fffc, 64'h7fff_f000, 64'hffff_ffff_ffff_e000, 64'h7fff_ffff,
    64'h1050, 64'hffff_ffff_8000_0010, 64'hf0, 64'h0123_4567_8000_0010,
    64'h0000_0000_beef_0000, 64'd100, 64'h98, 64'ha8,
    64'h0
};
localparam logic [7:0] exp_mask [n_stores] = '{
    8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff,
    8'hff, 8'hff, 8'hff, 8'hff, 8'h0c, 8'hff, 8'hff, 8'hff,
    8'hff
};

localparam logic [63:0] load_pc   [n_loads] = '{64'h58, 64'h60, 64'h68};
localparam logic [63:0] load_addr [n_loads] = '{64'h180, 64'h189, 64'h180};

function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
endfunction

function automatic logic [31:0] b_word(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
endfunction

function automatic logic [31:0] j_word(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
endfunction

task automatic load_program;
    imem[0]  = s_word(12'h1f8, 0, 0, 3);                 // sd x0, fetched during reset
    imem[1]  = i_word(12'h100, 0, 0, 10, opc_op_imm);     // x10 result base
    imem[2]  = i_word(12'h180, 0, 0, 11, opc_op_imm);     // x11 load area
    imem[3]  = i_word(12'd100, 0, 0, 1, opc_op_imm);
    imem[4]  = i_word(-12'sd7, 0, 0, 2, opc_op_imm);
    imem[5]  = r_word(7'h00, 2, 1, 0, 3, opc_op);         // add
    imem[6]  = s_word(12'd0, 3, 10, 3);
    imem[7]  = r_word(7'h20, 2, 1, 0, 4, opc_op);         // sub
    imem[8]  = s_word(12'd8, 4, 10, 3);
    imem[9]  = i_word(12'd101, 1, 3, 5, opc_op_imm);      // sltiu
    imem[10] = s_word(12'd16, 5, 10, 3);
    imem[11] = i_word(12'h401, 2, 5, 6, opc_op_imm);      // srai by 1
    imem[12] = s_word(12'd24, 6, 10, 3);
    imem[13] = {20'h7ffff, 5'd7, opc_lui};
    imem[14] = s_word(12'd32, 7, 10, 3);
    imem[15] = r_word(7'h00, 7, 7, 0, 8, opc_op_32);      // addw
    imem[16] = s_word(12'd40, 8, 10, 3);
    imem[17] = {20'h80000, 5'd9, opc_lui};
    imem[18] = i_word(12'hfff, 9, 0, 9, opc_op_imm_32);   // addiw -1
    imem[19] = s_word(12'd48, 9, 10, 3);
    imem[20] = {20'h00001, 5'd12, opc_auipc};
    imem[21] = s_word(12'd56, 12, 10, 3);
    imem[22] = i_word(12'd0, 11, 2, 13, opc_load);        // lw
    imem[23] = s_word(12'd64, 13, 10, 3);
    imem[24] = i_word(12'd9, 11, 4, 14, opc_load);        // lbu
    imem[25] = s_word(12'd72, 14, 10, 3);
    imem[26] = i_word(12'd0, 11, 3, 15, opc_load);        // ld
    imem[27] = s_word(12'd80, 15, 10, 3);
    imem[28] = {20'h0000c, 5'd16, opc_lui};
    imem[29] = i_word(12'heef, 16, 0, 16, opc_op_imm);    // x16 = 0xbeef
    imem[30] = s_word(12'd18, 16, 11, 1);                 // sh to 0x192
    imem[31] = b_word(13'd8, 1, 1, 0);                    // beq taken
    imem[32] = s_word(12'd88, 1, 10, 3);
    imem[33] = b_word(13'd8, 2, 1, 1);                    // bne taken
    imem[34] = s_word(12'd88, 1, 10, 3);
    imem[35] = b_word(13'd8, 2, 1, 0);                    // beq not taken
    imem[36] = s_word(12'd96, 1, 10, 3);
    imem[37] = j_word(21'd8, 17);
    imem[38] = s_word(12'd88, 1, 10, 3);
    imem[39] = s_word(12'd104, 17, 10, 3);
    imem[40] = i_word(12'd172, 0, 0, 19, opc_op_imm);
    imem[41] = i_word(12'd0, 19, 0, 18, opc_jalr);
    imem[42] = s_word(12'd88, 1, 10, 3);
    imem[43] = s_word(12'd112, 18, 10, 3);
    imem[44] = i_word(12'd55, 0, 0, 0, opc_op_imm);       // write to x0
    imem[45] = s_word(12'd120, 0, 10, 3);
    imem[46] = s_word(12'd0, 1, 10, 3'b111);              // store opcode, undefined funct3
    imem[47] = inst_ebreak;
    dmem[6'h30] = 64'h0123_4567_8000_0010;
    dmem[6'h31] = 64'h1122_3344_5566_f077;
    dmem[6'h32] = 64'h8877_6655_4433_2211;
endtask

`endif

/* tests/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core import rv_core_pkg::*; ();

    logic            clk;
    logic            rst_n;
    logic [31:0]     imem_rdata;
    logic [63:0]     dmem_rdata;
    imem_req_t       imem_req;
    dmem_req_t       dmem_req;
    logic            halt;
    logic            illegal;
    logic [31:0]     imem [64];
    logic [63:0]     dmem [64];
    int              cycles;
    int              stores_seen;

    `include "tb_program.svh"

    localparam int cycle_limit = 4 * prog_len;

    rv_core_top u_rv_core_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_rdata (imem_rdata),
        .imem_req   (imem_req),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .halt       (halt),
        .illegal    (illegal)
    );

    function automatic logic [63:0] fill_word(int i);
        return {56'h5a5a5a_0000_0000, 2'b00, i[5:0]};
    endfunction

    function automatic logic [63:0] byte_bits(logic [7:0] mask);
        logic [63:0] bits = '0;
        for (int b = 0; b < 8; b++) begin
            bits[b*8 +: 8] = {8{mask[b]}};
        end
        return bits;
    endfunction

    function automatic bit store_matches(dmem_req_t req);
        bit hit = 1'b0;
        for (int k = 0; k < n_stores; k++) begin
            if (req.addr == exp_addr[k]) begin
                hit = (req.wmask == exp_mask[k]) &&
                      ((req.wdata & byte_bits(req.wmask)) == exp_data[k]);
            end
        end
        return hit;
    endfunction

    function automatic bit load_matches(dmem_req_t req, logic [63:0] pc);
        bit at_load = 1'b0;
        bit addr_ok = 1'b0;
        for (int k = 0; k < n_loads; k++) begin
            if (pc == load_pc[k]) begin
                at_load = 1'b1;
                addr_ok = (req.addr == load_addr[k]);
            end
        end
        return (req.ren == at_load) && (!at_load || addr_ok);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    assign imem_rdata = imem[imem_req.addr[7:2]];   // combinational fetch
    assign dmem_rdata = dmem[dmem_req.addr[8:3]];

    always @(posedge clk) begin
        if (dmem_req.wen) begin
            for (int b = 0; b < 8; b++) begin
                if (dmem_req.wmask[b]) begin
                    dmem[dmem_req.addr[8:3]][b*8 +: 8] <= dmem_req.wdata[b*8 +: 8];
                end
            end
            stores_seen <= stores_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit + 5) begin
            abort_run($sformatf("timeout: halt not reached after %0d cycles", cycles));
        end
    end

    a_reset: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (imem_req.addr == reset_pc && !dmem_req.wen))
        else abort_run($sformatf("** Error at %0t: fetch or store active in reset", $time));

    a_store: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.wen |-> store_matches(dmem_req))
        else abort_run($sformatf("** Error at %0t: store addr %h data %h mask %h",
                                 $time, dmem_req.addr, dmem_req.wdata, dmem_req.wmask));

    a_load: assert property (@(posedge clk) disable iff (!rst_n)
        load_matches(dmem_req, imem_req.addr))
        else abort_run($sformatf("** Error at %0t: load ren %b addr %h at pc %h",
                                 $time, dmem_req.ren, dmem_req.addr, imem_req.addr));

    a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        (illegal == (imem_req.addr == illegal_pc)) && !(illegal && dmem_req.wen))
        else abort_run($sformatf("** Error at %0t: illegal %b at pc %h",
                                 $time, illegal, imem_req.addr));

    a_illegal_next: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |=> (imem_req.addr == illegal_pc + 4))
        else abort_run($sformatf("** Error at %0t: pc %h after unknown encoding",
                                 $time, imem_req.addr));

    a_halt_rise: assert property (@(posedge clk) disable iff (!rst_n)
        (imem_rdata == inst_ebreak && !halt) |=> halt)
        else abort_run($sformatf("** Error at %0t: halt missing after ebreak", $time));

    a_halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        halt |=> (halt && $stable(imem_req.addr) && !dmem_req.wen))
        else abort_run($sformatf("** Error at %0t: core moved while halted", $time));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n       = 1'b0;
        cycles      = 0;
        stores_seen = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = {i[24:0], 7'h7f};             // unknown opcode everywhere
            dmem[i] = fill_word(i);
        end
        load_program();
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        wait (halt);
        repeat (6) @(posedge clk);
        if (stores_seen == n_stores && dmem[6'h32] == 64'h8877_6655_beef_2211 &&
            dmem[poison_addr[8:3]] == fill_word(int'(poison_addr[8:3]))) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("** Error at %0t: %0d stores, sh word %h, poison word %h",
                                $time, stores_seen, dmem[6'h32], dmem[poison_addr[8:3]]));
        end
    end

endmodule
